// ==== bench/tb_pat_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pat_core;

	localparam int pc_width  = 10;
	localparam int rom_depth = 1 << pc_width;

	logic                clk = 1'b0;
	logic                reset;
	isa_pkg::instr_t     i_instruction;
	logic [pc_width-1:0] o_pc;
	logic                o_jump;
	cpu_pkg::data_t      o_out;
	logic                o_out_valid;

	isa_pkg::instr_t     program_rom [rom_depth]; // testbench acts as instruction memory
	cpu_pkg::data_t      model_regs [8];          // reference register file
	logic                model_z;
	logic                model_n;
	cpu_pkg::data_t      exp_q [$];               // expected OUT values, program order
	logic [pc_width-1:0] tgt_q [$];               // expected branch targets
	cpu_pkg::data_t      exp_head;
	logic                exp_pending = 1'b0;
	logic                tgt_pending = 1'b0;
	logic [pc_width-1:0] last_target;
	int                  prog_len;
	int                  cycle_count = 0;
	int                  cycle_limit = 100;
	logic [31:0]         rng_state = 32'h87f4;

	pat_core #(.pc_width(pc_width)) u_pat_core (
		.clk           (clk),
		.reset         (reset),
		.i_instruction (i_instruction),
		.o_pc          (o_pc),
		.o_jump        (o_jump),
		.o_out         (o_out),
		.o_out_valid   (o_out_valid)
	);

	always #5 clk = ~clk; // 10 ns period

	always @(negedge clk)
		i_instruction <= program_rom[o_pc]; // memory answers on the falling edge

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_value(input string name, input int got, input int expected);
		$display("CHECK FAILED t=%0t %s got=%0h expected=%0h", $time, name, got, expected);
		abort_run();
	endtask

	// ==================================================
	// scoreboard and watchdog
	// ==================================================
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("watchdog expired, expected outputs or jumps never arrived");
			abort_run();
		end
		if (o_out_valid && exp_q.size() > 0)
			void'(exp_q.pop_front()); // head consumed by this strobe
		if (o_jump && tgt_q.size() > 0)
		begin
			last_target <= tgt_q[0];
			void'(tgt_q.pop_front());
		end
		exp_pending <= (exp_q.size() > 0);
		exp_head    <= (exp_q.size() > 0) ? exp_q[0] : '0;
		tgt_pending <= (tgt_q.size() > 0);
	end

	a_reset_pc : assert property (@(posedge clk) reset |=> (o_pc == '0))
		else report_value("o_pc", $sampled(o_pc), 0);
	a_reset_jump : assert property (@(posedge clk) reset |=> !o_jump)
		else report_value("o_jump", $sampled(o_jump), 0);
	a_reset_out : assert property (@(posedge clk) reset |=> !o_out_valid)
		else report_value("o_out_valid", $sampled(o_out_valid), 0);
	a_out_expected : assert property (@(posedge clk) disable iff (reset)
		o_out_valid |-> exp_pending)
		else begin
			$display("OUT strobe at t=%0t with no expected value left", $time);
			abort_run();
		end
	a_out_value : assert property (@(posedge clk) disable iff (reset)
		o_out_valid |-> (o_out == exp_head))
		else report_value("o_out", $sampled(o_out), $sampled(exp_head));
	a_jump_expected : assert property (@(posedge clk) disable iff (reset)
		o_jump |-> tgt_pending)
		else begin
			$display("jump at t=%0t where no taken branch was expected", $time);
			abort_run();
		end
	a_jump_target : assert property (@(posedge clk) disable iff (reset)
		o_jump |=> (o_pc == last_target))
		else report_value("o_pc", $sampled(o_pc), $sampled(last_target));

	// ==================================================
	// encoding and reference model
	// ==================================================
	function automatic isa_pkg::instr_t make_i8(input cpu_pkg::reg_addr_t rd,
		input isa_pkg::cond_e cond, input logic [3:0] op, input cpu_pkg::data_t imm);
		return {rd, cond, op, imm};
	endfunction

	function automatic isa_pkg::instr_t make_i3(input cpu_pkg::reg_addr_t rd,
		input isa_pkg::cond_e cond, input logic [3:0] op, input logic [2:0] amt);
		return {rd, cond, 4'hf, op, 1'b0, amt}; // amt is shift or rs
	endfunction

	function automatic isa_pkg::instr_t make_i0(input cpu_pkg::reg_addr_t rd,
		input isa_pkg::cond_e cond, input logic [3:0] op);
		return {rd, cond, 4'hf, 4'hf, op};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic cond_holds(input isa_pkg::cond_e cond);
		case (cond)
			isa_pkg::cond_z:  return model_z;
			isa_pkg::cond_nz: return !model_z;
			isa_pkg::cond_n:  return model_n;
			default:          return 1'b1;
		endcase
	endfunction

	task automatic run_model(input isa_pkg::instr_t w);
		cpu_pkg::data_t a;
		cpu_pkg::data_t b;
		cpu_pkg::data_t y;
		int             n;
		a = model_regs[w.rd];
		if (!cond_holds(w.cond))
			return; // false condition, nothing commits
		if (w.opcode != 4'hf)
		begin
			b = w.opcode[0] ? model_regs[w.imm[2:0]] : w.imm; // odd = register source
			case (w.opcode)
				isa_pkg::op_ori, isa_pkg::op_orr:   model_regs[w.rd] = a | b;
				isa_pkg::op_andi, isa_pkg::op_andr: model_regs[w.rd] = a & b;
				isa_pkg::op_addi, isa_pkg::op_addr:
					model_regs[w.rd] = cpu_pkg::data_t'((int'(a) + int'(b)) % 256);
				isa_pkg::op_subi, isa_pkg::op_subr:
					model_regs[w.rd] = cpu_pkg::data_t'((int'(a) - int'(b) + 256) % 256);
				isa_pkg::op_ldi: model_regs[w.rd] = w.imm;
				default: ;
			endcase
		end
		else if (w.imm[7:4] != 4'hf)
		begin
			n = w.imm[4] ? int'(model_regs[w.imm[2:0]][2:0]) : int'(w.imm[2:0]);
			y = a >> n;
			case (w.imm[7:4])
				isa_pkg::op_shlzi, isa_pkg::op_shlzr: model_regs[w.rd] = a << n;
				isa_pkg::op_shloi, isa_pkg::op_shlor:
					model_regs[w.rd] = (a << n) | ((8'd1 << n) - 8'd1); // ones shifted in
				isa_pkg::op_shrzi, isa_pkg::op_shrzr: model_regs[w.rd] = y;
				isa_pkg::op_asri, isa_pkg::op_asrr:
					model_regs[w.rd] = a[7] ? (y | ~(8'hff >> n)) : y;
				isa_pkg::op_out: exp_q.push_back(a);
				default: ;
			endcase
		end
		else if (w.imm[3:0] == isa_pkg::op_not)
			model_regs[w.rd] = ~a;
		else if (w.imm[3:0] == isa_pkg::op_test)
		begin
			model_z = (a == 8'h00);
			model_n = a[7];
		end
	endtask

	task automatic place(input int addr, input isa_pkg::instr_t w);
		program_rom[addr] = w;
		if (addr >= prog_len)
			prog_len = addr + 1;
	endtask

	task automatic emit_at(input int addr, input isa_pkg::instr_t w);
		place(addr, w);
		run_model(w);
	endtask

	task automatic emit(input isa_pkg::instr_t w);
		emit_at(prog_len, w); // append
	endtask

	// BF target is its own address plus the signed offset
	task automatic branch_at(input int addr, input isa_pkg::cond_e cond, input int offset);
		place(addr, make_i8(3'd0, cond, isa_pkg::op_bf, 8'(offset)));
		if (cond_holds(cond))
			tgt_q.push_back(pc_width'(addr + offset));
	endtask

	task automatic start_program();
		@(negedge clk);
		reset = 1'b1; // core held while memory is rewritten
		for (int i = 0; i < rom_depth; i++)
			program_rom[i] = make_i0(3'd0, isa_pkg::cond_al, isa_pkg::op_nop);
		prog_len = 0;
		model_z  = 1'b0;
		model_n  = 1'b0;
	endtask

	task automatic run_program();
		cycle_limit = cycle_count + prog_len * 10 + 40;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		while (exp_q.size() != 0 || tgt_q.size() != 0)
			@(negedge clk);
		repeat (8) @(negedge clk); // catch stray strobes after the last one
	endtask

	// ==================================================
	// tests
	// ==================================================
	initial
	begin
		reset         = 1'b1;
		i_instruction = make_i0(3'd0, isa_pkg::cond_al, isa_pkg::op_nop);
		prog_len      = 0;

		// arithmetic and logic with wrap
		start_program();
		emit(make_i8(3'd0, isa_pkg::cond_al, isa_pkg::op_ldi, 8'hc3));
		emit(make_i8(3'd1, isa_pkg::cond_al, isa_pkg::op_ldi, 8'h5e));
		emit(make_i8(3'd0, isa_pkg::cond_al, isa_pkg::op_addi, 8'h71));
		emit(make_i8(3'd0, isa_pkg::cond_al, isa_pkg::op_addr, 8'd1));
		emit(make_i8(3'd2, isa_pkg::cond_al, isa_pkg::op_ldi, 8'h10));
		emit(make_i8(3'd2, isa_pkg::cond_al, isa_pkg::op_subr, 8'd0)); // borrows
		emit(make_i3(3'd2, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		emit(make_i8(3'd1, isa_pkg::cond_al, isa_pkg::op_andi, 8'h3c));
		emit(make_i8(3'd1, isa_pkg::cond_al, isa_pkg::op_orr, 8'd2));
		emit(make_i0(3'd1, isa_pkg::cond_al, isa_pkg::op_not));
		emit(make_i3(3'd1, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		emit(make_i3(3'd0, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		run_program();

		// four shift kinds, immediate and register amount, negative and positive value
		start_program();
		emit(make_i8(3'd1, isa_pkg::cond_al, isa_pkg::op_ldi, 8'h0b)); // amount 3 in r1
		for (int v = 0; v < 2; v++)
			for (int k = 0; k < 8; k++)
			begin
				emit(make_i8(3'd2, isa_pkg::cond_al, isa_pkg::op_ldi, v ? 8'h4d : 8'hb5));
				emit(make_i3(3'd2, isa_pkg::cond_al, 4'(k), k[0] ? 3'd1 : 3'(k / 2 + 2)));
				emit(make_i3(3'd2, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
			end
		run_program();

		// branches in execution order, wrong-path slots output the marker in r2
		start_program();
		emit(make_i8(3'd0, isa_pkg::cond_al, isa_pkg::op_ldi, 8'h00));
		emit(make_i8(3'd1, isa_pkg::cond_al, isa_pkg::op_ldi, 8'h5a));
		emit(make_i8(3'd2, isa_pkg::cond_al, isa_pkg::op_ldi, 8'hee));
		emit(make_i0(3'd0, isa_pkg::cond_al, isa_pkg::op_test)); // z set
		branch_at(4, isa_pkg::cond_z, 9);
		place(5, make_i3(3'd2, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		place(6, make_i3(3'd2, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		branch_at(13, isa_pkg::cond_nz, 5); // falls through
		emit_at(14, make_i3(3'd1, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		branch_at(15, isa_pkg::cond_al, -8); // backwards
		place(16, make_i3(3'd2, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		place(17, make_i3(3'd2, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		emit_at(7, make_i8(3'd1, isa_pkg::cond_al, isa_pkg::op_addi, 8'h01));
		emit_at(8, make_i3(3'd1, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		branch_at(9, isa_pkg::cond_al, 12);
		place(10, make_i3(3'd2, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		place(11, make_i3(3'd2, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		emit_at(21, make_i3(3'd0, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		run_program();

		// conditional execution on z, nz and n
		start_program();
		emit(make_i8(3'd0, isa_pkg::cond_al, isa_pkg::op_ldi, 8'h80));
		emit(make_i8(3'd1, isa_pkg::cond_al, isa_pkg::op_ldi, 8'h11));
		emit(make_i0(3'd1, isa_pkg::cond_al, isa_pkg::op_test));   // z=0 n=0
		emit(make_i8(3'd1, isa_pkg::cond_z, isa_pkg::op_ldi, 8'h22));
		emit(make_i3(3'd1, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		emit(make_i8(3'd1, isa_pkg::cond_n, isa_pkg::op_ldi, 8'h33));
		emit(make_i3(3'd1, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		emit(make_i0(3'd0, isa_pkg::cond_al, isa_pkg::op_test));   // n=1
		emit(make_i8(3'd1, isa_pkg::cond_n, isa_pkg::op_ldi, 8'h44));
		emit(make_i3(3'd1, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		emit(make_i8(3'd1, isa_pkg::cond_z, isa_pkg::op_addi, 8'h01));
		emit(make_i3(3'd1, isa_pkg::cond_nz, isa_pkg::op_out, 3'd0));
		emit(make_i3(3'd1, isa_pkg::cond_z, isa_pkg::op_out, 3'd0)); // suppressed
		emit(make_i8(3'd1, isa_pkg::cond_nz, isa_pkg::op_ldi, 8'h55));
		emit(make_i3(3'd1, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		run_program();

		// random operands, r3 op r4 or op imm
		start_program();
		for (int i = 0; i < 20; i++)
		begin
			rng_state = xorshift(rng_state);
			emit(make_i8(3'd3, isa_pkg::cond_al, isa_pkg::op_ldi, rng_state[7:0]));
			emit(make_i8(3'd4, isa_pkg::cond_al, isa_pkg::op_ldi, rng_state[15:8]));
			emit(make_i8(3'd3, isa_pkg::cond_al, {1'b0, rng_state[18:16]},
				rng_state[16] ? 8'd4 : rng_state[31:24]));
			emit(make_i3(3'd3, isa_pkg::cond_al, isa_pkg::op_out, 3'd0));
		end
		run_program();

		if (exp_q.size() == 0 && tgt_q.size() == 0)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
		begin
			$display("expected outputs left over at end of run");
			abort_run();
		end
	end

endmodule

`default_nettype wire

// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// ==================================================
	// datapath widths
	// ==================================================
	localparam int data_width  = 8;  // register and alu word
	localparam int reg_count   = 8;  // entries in the register file
	localparam int addr_width  = 16; // widest code address carried between stages

	typedef logic [data_width-1:0]        data_t;      // register / operand / output word
	typedef logic [2:0]                   reg_addr_t;  // register index
	typedef logic [2:0]                   shamt_t;     // shift distance 0..7
	typedef logic signed [data_width-1:0] offset_t;    // branch displacement, two's complement
	typedef logic [addr_width-1:0]        code_addr_t; // instruction address, pc_width bits used

	// execute -> fetch, taken branch
	typedef struct packed {
		logic       taken;  // high for the one cycle of a taken BF
		code_addr_t target; // address of the BF plus its offset
	} redirect_t;

	// output port register
	typedef struct packed {
		logic  valid; // one-cycle strobe
		data_t data;  // value of rd at the OUT
	} out_port_t;

endpackage

`default_nettype wire

// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	// marks i3 class in opcode, and i0 class in imm[7:4]
	localparam logic [3:0] i3_prefix = 4'b1111;

	// condition codes, evaluated against the flags in execute
	typedef enum logic [1:0] {
		cond_z  = 2'd0, // zero
		cond_nz = 2'd1, // not zero
		cond_n  = 2'd2, // negative
		cond_al = 2'd3  // always
	} cond_e;

	// raw instruction word, 17 bits
	typedef struct packed {
		cpu_pkg::reg_addr_t rd;     // destination, also operand a
		cond_e              cond;   // per-instruction condition
		logic [3:0]         opcode; // i8 opcode or i3 prefix
		cpu_pkg::data_t     imm;    // immediate / sub-opcodes / rs
	} instr_t;

	// i8 class, opcode field
	localparam logic [3:0] op_ori  = 4'd0;
	localparam logic [3:0] op_orr  = 4'd1;
	localparam logic [3:0] op_andi = 4'd2;
	localparam logic [3:0] op_andr = 4'd3;
	localparam logic [3:0] op_addi = 4'd4;
	localparam logic [3:0] op_addr = 4'd5;
	localparam logic [3:0] op_subi = 4'd6;
	localparam logic [3:0] op_subr = 4'd7;
	localparam logic [3:0] op_ldi  = 4'd8;
	localparam logic [3:0] op_bf   = 4'd13;

	// i3 class, imm[7:4]
	localparam logic [3:0] op_shlzi = 4'd0;
	localparam logic [3:0] op_shlzr = 4'd1;
	localparam logic [3:0] op_shloi = 4'd2;
	localparam logic [3:0] op_shlor = 4'd3;
	localparam logic [3:0] op_shrzi = 4'd4;
	localparam logic [3:0] op_shrzr = 4'd5;
	localparam logic [3:0] op_asri  = 4'd6;
	localparam logic [3:0] op_asrr  = 4'd7;
	localparam logic [3:0] op_out   = 4'd11;

	// i0 class, imm[3:0]
	localparam logic [3:0] op_not  = 4'd0;
	localparam logic [3:0] op_test = 4'd2;
	localparam logic [3:0] op_nop  = 4'd15;

	// ten operations, so four bits
	typedef enum logic [3:0] {
		alu_or, alu_and, alu_add, alu_sub, alu_not,
		alu_shlz, alu_shlo, alu_shrz, alu_asr, alu_pass_b
	} alu_op_e;

	// decode -> execute register
	typedef struct packed {
		logic                valid;
		cpu_pkg::reg_addr_t  rd;
		cpu_pkg::reg_addr_t  rs;
		cond_e               cond;
		alu_op_e             alu_op;
		logic                use_imm;    // operand b from imm instead of rs
		cpu_pkg::data_t      imm;        // expanded immediate or branch offset
		logic                writes_reg;
		logic                is_test;
		logic                is_out;
		logic                is_branch;
		cpu_pkg::code_addr_t pc;         // address of this instruction
	} decoded_t;

endpackage

`default_nettype wire

// ==== design/execute/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire cpu_pkg::data_t   i_a,
	input  wire cpu_pkg::data_t   i_b,
	input  wire isa_pkg::alu_op_e i_op,
	output cpu_pkg::data_t        o_y
);

	cpu_pkg::shamt_t amt;
	cpu_pkg::data_t  b_add;   // b or ~b for subtract
	cpu_pkg::data_t  sum;
	logic            is_sub;

	assign amt    = i_b[2:0]; // shift distance
	assign is_sub = (i_op == isa_pkg::alu_sub);
	assign b_add  = is_sub ? ~i_b : i_b;
	assign sum    = i_a + b_add + cpu_pkg::data_t'(is_sub); // a + ~b + 1

	always_comb
	begin
		case (i_op)
			isa_pkg::alu_or:   o_y = i_a | i_b;
			isa_pkg::alu_and:  o_y = i_a & i_b;
			isa_pkg::alu_add,
			isa_pkg::alu_sub:  o_y = sum;              // wraps at 8 bits
			isa_pkg::alu_not:  o_y = ~i_a;
			isa_pkg::alu_shlz: o_y = i_a << amt;
			isa_pkg::alu_shlo: o_y = ~((~i_a) << amt); // ones into vacated low bits
			isa_pkg::alu_shrz: o_y = i_a >> amt;
			isa_pkg::alu_asr:  o_y = cpu_pkg::data_t'($signed(i_a) >>> amt); // sign fill
			default:           o_y = i_b;              // pass b, LDI
		endcase
	end

endmodule

`default_nettype wire

// ==== design/execute/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire isa_pkg::decoded_t i_decoded,
	output cpu_pkg::redirect_t     o_redirect,
	output cpu_pkg::data_t         o_out,
	output logic                   o_out_valid
);

	cpu_pkg::data_t    rd_data;  // operand a, also TEST / OUT source
	cpu_pkg::data_t    rs_data;
	cpu_pkg::data_t    op_b;
	cpu_pkg::data_t    alu_y;
	cpu_pkg::offset_t  offset;   // branch displacement
	cpu_pkg::out_port_t out_q;
	logic flag_z;
	logic flag_n;
	logic cond_true;
	logic fire;                  // valid and condition met

	register_file u_register_file (
		.clk       (clk),
		.i_rd_addr (i_decoded.rd),
		.i_rs_addr (i_decoded.rs),
		.i_we      (fire && i_decoded.writes_reg),
		.i_wdata   (alu_y),
		.o_rd_data (rd_data),
		.o_rs_data (rs_data)
	);

	assign op_b = i_decoded.use_imm ? i_decoded.imm : rs_data;

	alu u_alu (
		.i_a  (rd_data),
		.i_b  (op_b),
		.i_op (i_decoded.alu_op),
		.o_y  (alu_y)
	);

	// ==================================================
	// condition check against current flags
	// ==================================================
	always_comb
	begin
		case (i_decoded.cond)
			isa_pkg::cond_z:  cond_true = flag_z;
			isa_pkg::cond_nz: cond_true = !flag_z;
			isa_pkg::cond_n:  cond_true = flag_n;
			default:          cond_true = 1'b1; // always
		endcase
	end

	assign fire = i_decoded.valid && cond_true;

	// branch resolution, combinational from the execute register
	assign offset            = cpu_pkg::offset_t'(i_decoded.imm);
	assign o_redirect.taken  = fire && i_decoded.is_branch;
	assign o_redirect.target = i_decoded.pc + {{8{offset[7]}}, offset}; // sign-extended

	// flags and output port commit
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flag_z      <= 1'b0;
			flag_n      <= 1'b0;
			out_q.valid <= 1'b0;
		end
		else
		begin
			if (fire && i_decoded.is_test)
			begin
				flag_z <= (rd_data == '0);
				flag_n <= rd_data[7]; // msb is the sign
			end
			out_q.valid <= fire && i_decoded.is_out; // one-cycle pulse
		end
		if (fire && i_decoded.is_out)
			out_q.data <= rd_data;
	end

	assign o_out       = out_q.data;
	assign o_out_valid = out_q.valid;

	// the BF itself and both squashed slots must stay silent
	a_no_out_after_jump : assert property (@(posedge clk) disable iff (reset)
		o_redirect.taken |=> !o_out_valid [*3]);

endmodule

`default_nettype wire

// ==== design/execute/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire logic               clk,
	input  wire cpu_pkg::reg_addr_t i_rd_addr,
	input  wire cpu_pkg::reg_addr_t i_rs_addr,
	input  wire logic               i_we,
	input  wire cpu_pkg::data_t     i_wdata,
	output cpu_pkg::data_t          o_rd_data,
	output cpu_pkg::data_t          o_rs_data
);

	cpu_pkg::data_t regs [cpu_pkg::reg_count]; // contents undefined after reset

	// write lands at the edge, seen by the next execute read
	always_ff @(posedge clk)
	begin
		if (i_we)
			regs[i_rd_addr] <= i_wdata; // write goes to rd
	end

	assign o_rd_data = regs[i_rd_addr];
	assign o_rs_data = regs[i_rs_addr];

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter int pc_width = 10
) (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire isa_pkg::instr_t     i_instruction,   // word at o_pc from program memory
	input  wire cpu_pkg::redirect_t  i_redirect,
	output logic [pc_width-1:0]      o_pc,
	output isa_pkg::instr_t          o_fetched,
	output logic [pc_width-1:0]      o_fetched_pc,
	output logic                     o_fetched_valid
);

	// program counter
	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (i_redirect.taken)
			o_pc <= i_redirect.target[pc_width-1:0]; // low bits only
		else
			o_pc <= o_pc + 1'b1;
	end

	// capture register holds the word plus the address it came from
	always_ff @(posedge clk)
	begin
		o_fetched    <= i_instruction;
		o_fetched_pc <= o_pc;
		o_fetched_valid <= !(reset || i_redirect.taken); // wrong-path slot dropped on redirect
	end

	// ==================================================
	// checks
	// ==================================================
	// branch target must fit the pc and be the next address presented to memory
	a_redirect_pc : assert property (@(posedge clk) disable iff (reset)
		i_redirect.taken |=> (cpu_pkg::code_addr_t'(o_pc) == $past(i_redirect.target)));

endmodule

`default_nettype wire

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder #(
	parameter int pc_width = 10
) (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire isa_pkg::instr_t     i_fetched,
	input  wire logic [pc_width-1:0] i_fetched_pc,
	input  wire logic                i_fetched_valid,
	input  wire logic                i_flush,         // taken branch in execute
	output isa_pkg::decoded_t        o_decoded
);

	logic is_i8;
	logic is_i3;
	isa_pkg::decoded_t dec; // next value of the decode register

	// class by prefix
	assign is_i8 = (i_fetched.opcode != isa_pkg::i3_prefix);
	assign is_i3 = !is_i8 && (i_fetched.imm[7:4] != isa_pkg::i3_prefix);

	always_comb
	begin
		dec            = '0;
		dec.alu_op     = isa_pkg::alu_pass_b;
		dec.valid      = i_fetched_valid;
		dec.rd         = i_fetched.rd;
		dec.rs         = i_fetched.imm[2:0]; // register source for r-forms
		dec.cond       = i_fetched.cond;
		dec.pc         = cpu_pkg::code_addr_t'(i_fetched_pc);
		if (is_i8)
		begin
			// ==================================================
			// i8: full 8-bit immediate, even opcode = immediate form
			dec.imm     = i_fetched.imm;
			dec.use_imm = ~i_fetched.opcode[0];
			case (i_fetched.opcode)
				isa_pkg::op_ori, isa_pkg::op_orr:   {dec.alu_op, dec.writes_reg} = {isa_pkg::alu_or, 1'b1};
				isa_pkg::op_andi, isa_pkg::op_andr: {dec.alu_op, dec.writes_reg} = {isa_pkg::alu_and, 1'b1};
				isa_pkg::op_addi, isa_pkg::op_addr: {dec.alu_op, dec.writes_reg} = {isa_pkg::alu_add, 1'b1};
				isa_pkg::op_subi, isa_pkg::op_subr: {dec.alu_op, dec.writes_reg} = {isa_pkg::alu_sub, 1'b1};
				isa_pkg::op_ldi:  dec.writes_reg = 1'b1; // pass b with the immediate
				isa_pkg::op_bf:   dec.is_branch  = 1'b1; // imm is the signed offset
				default:          dec.valid      = i_fetched_valid; // unassigned opcode, nop
			endcase
		end
		else if (is_i3)
		begin
			// ==================================================
			// i3: shift amount or rs in imm[2:0]
			dec.imm     = cpu_pkg::data_t'(i_fetched.imm[2:0]);
			dec.use_imm = ~i_fetched.imm[4];
			case (i_fetched.imm[7:4])
				isa_pkg::op_shlzi, isa_pkg::op_shlzr: {dec.alu_op, dec.writes_reg} = {isa_pkg::alu_shlz, 1'b1};
				isa_pkg::op_shloi, isa_pkg::op_shlor: {dec.alu_op, dec.writes_reg} = {isa_pkg::alu_shlo, 1'b1};
				isa_pkg::op_shrzi, isa_pkg::op_shrzr: {dec.alu_op, dec.writes_reg} = {isa_pkg::alu_shrz, 1'b1};
				isa_pkg::op_asri, isa_pkg::op_asrr:   {dec.alu_op, dec.writes_reg} = {isa_pkg::alu_asr, 1'b1};
				isa_pkg::op_out:  dec.is_out = 1'b1;
				default:          dec.is_out = 1'b0; // nop
			endcase
		end
		else
		begin
			// i0: operates on rd alone
			case (i_fetched.imm[3:0])
				isa_pkg::op_not:  {dec.alu_op, dec.writes_reg} = {isa_pkg::alu_not, 1'b1};
				isa_pkg::op_test: dec.is_test = 1'b1;
				isa_pkg::op_nop:  dec.is_test = 1'b0;
				default:          dec.is_test = 1'b0; // unassigned, nop
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		o_decoded <= dec;
		if (reset || i_flush)
			o_decoded.valid <= 1'b0; // squash wrong-path slot
	end

	// one commit kind per instruction
	a_one_kind : assert property (@(posedge clk) disable iff (reset)
		o_decoded.valid |-> $onehot0({o_decoded.writes_reg, o_decoded.is_test,
			o_decoded.is_out, o_decoded.is_branch}));

endmodule

`default_nettype wire

// ==== design/pat_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module pat_core #(
	parameter int pc_width = 10 // instruction address width
) (
	input  wire logic            clk,
	input  wire logic            reset,
	input  wire isa_pkg::instr_t i_instruction,
	output logic [pc_width-1:0]  o_pc,
	output logic                 o_jump,
	output cpu_pkg::data_t       o_out,
	output logic                 o_out_valid
);

	isa_pkg::instr_t      fetched;
	logic [pc_width-1:0]  fetched_pc;
	logic                 fetched_valid;
	isa_pkg::decoded_t    decoded;
	cpu_pkg::redirect_t   redirect;

	// ==================================================
	// fetch -> decode -> execute
	// ==================================================
	fetch_unit #(.pc_width(pc_width)) u_fetch_unit (
		.clk             (clk),
		.reset           (reset),
		.i_instruction   (i_instruction),
		.i_redirect      (redirect),
		.o_pc            (o_pc),
		.o_fetched       (fetched),
		.o_fetched_pc    (fetched_pc),
		.o_fetched_valid (fetched_valid)
	);

	instr_decoder #(.pc_width(pc_width)) u_instr_decoder (
		.clk             (clk),
		.reset           (reset),
		.i_fetched       (fetched),
		.i_fetched_pc    (fetched_pc),
		.i_fetched_valid (fetched_valid),
		.i_flush         (redirect.taken),
		.o_decoded       (decoded)
	);

	execute_unit u_execute_unit (
		.clk         (clk),
		.reset       (reset),
		.i_decoded   (decoded),
		.o_redirect  (redirect),
		.o_out       (o_out),
		.o_out_valid (o_out_valid)
	);

	assign o_jump = redirect.taken; // one cycle per taken BF

endmodule

`default_nettype wire

// ==== project.f ====
common/cpu_pkg.sv
common/isa_pkg.sv
design/fetch_unit.sv
design/instr_decoder.sv
design/execute/alu.sv
design/execute/register_file.sv
design/execute/execute_unit.sv
design/pat_core.sv
bench/tb_pat_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_pat_core -f project.f \
	-Mdir obj_dir -o sim_pat_core \
	|| { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/sim_pat_core 2>&1)"
echo "$sim_out"
grep -q "ALL TESTS PASSED" <<< "$sim_out" && exit 0 || exit 1
